/* cp0_asserts.sv */
`timescale 1ns/1ps

`include "cp0_settings.svh"

module cp0_asserts (
   input logic              clk,
   input logic              rst,
   input logic              stall_i,
   input cp0_pkg::commit_t  commit_i,
   input cp0_pkg::exc_req_t exc_req_i,
   input logic [31:0]       status_i,
   input logic              flush_i,
   input logic              timer_int_i
);

   logic sync_flag;

   assign sync_flag = commit_i.adel_fetch | commit_i.ri | commit_i.ov | commit_i.sys
                    | commit_i.bp | commit_i.adel_load | commit_i.ades | commit_i.eret;

   // resolver acts on a live commit only
   a_flush_needs_commit: assert property (@(posedge clk) disable iff (rst)
      flush_i |-> (commit_i.valid && !stall_i))
      else $error("flush without a valid unstalled commit");

   // any flagged live commit must leave the pipeline
   a_flag_forces_flush: assert property (@(posedge clk) disable iff (rst)
      (commit_i.valid && !stall_i && sync_flag) |-> flush_i)
      else $error("flagged commit retired without a flush");

   a_exl_after_entry: assert property (@(posedge clk) disable iff (rst)
      (flush_i && !exc_req_i.eret) |=> status_i[`CP0_STATUS_EXL])
      else $error("exl not set one cycle after exception entry");

   a_no_flush_in_reset: assert property (@(posedge clk)
      rst |-> !flush_i)
      else $error("flush during reset");

   // also covers the first cycle out of reset
   a_quiet_after_reset: assert property (@(posedge clk)
      rst |=> (!flush_i && !timer_int_i))
      else $error("flush or timer interrupt right after reset");

endmodule

bind cp0_top cp0_asserts asserts0 (
   .clk         (clk),
   .rst         (rst),
   .stall_i     (stall_i),
   .commit_i    (commit_i),
   .exc_req_i   (exc_req),
   .status_i    (status),
   .flush_i     (flush_o),
   .timer_int_i (timer_int_o)
);

/* cp0_exc_resolve.sv */
`timescale 1ns/1ps

`include "cp0_settings.svh"

module cp0_exc_resolve (
   input  cp0_pkg::commit_t  commit_i,
   input  logic              stall_i,
   input  logic [31:0]       status_i,
   input  logic [31:0]       cause_i,
   input  logic [31:0]       epc_i,
   output cp0_pkg::exc_req_t exc_req_o,
   output logic              flush_o,
   output logic [31:0]       redirect_pc_o
);

   logic               retire;
   logic [7:0]         int_masked;
   logic               int_pending;
   logic               exc_hit;
   logic               bad_from_pc;
   logic               bad_from_mem;
   cp0_pkg::exc_code_e exc_code;

   assign retire = commit_i.valid & ~stall_i;

   // ip & im, only outside exception level
   assign int_masked  = cause_i[`CP0_CAUSE_IP_HI:`CP0_CAUSE_IP_LO]
                      & status_i[`CP0_STATUS_IM_HI:`CP0_STATUS_IM_LO];
   assign int_pending = (|int_masked) & status_i[`CP0_STATUS_IE]
                      & ~status_i[`CP0_STATUS_EXL];

   // fixed priority, first match wins
   always_comb begin
      exc_hit      = 1'b1;
      bad_from_pc  = 1'b0;
      bad_from_mem = 1'b0;
      exc_code     = cp0_pkg::INT;
      if (int_pending) begin
         exc_code = cp0_pkg::INT;
      end else if (commit_i.adel_fetch) begin
         exc_code    = cp0_pkg::ADEL;
         bad_from_pc = 1'b1;
      end else if (commit_i.ri) begin
         exc_code = cp0_pkg::RI;
      end else if (commit_i.ov) begin
         exc_code = cp0_pkg::OV;
      end else if (commit_i.sys) begin
         exc_code = cp0_pkg::SYS;
      end else if (commit_i.bp) begin
         exc_code = cp0_pkg::BP;
      end else if (commit_i.adel_load) begin
         exc_code     = cp0_pkg::ADEL;
         bad_from_mem = 1'b1;
      end else if (commit_i.ades) begin
         exc_code     = cp0_pkg::ADES;
         bad_from_mem = 1'b1;
      end else begin
         exc_hit = 1'b0;  // eret or clean retire
      end
   end

   always_comb begin
      exc_req_o.take = retire & exc_hit;
      exc_req_o.eret = retire & ~exc_hit & commit_i.eret;
      exc_req_o.code = exc_code;
      exc_req_o.bd   = commit_i.in_delay_slot;

      // restart at the branch when the victim sits in its delay slot
      if (commit_i.in_delay_slot) begin
         exc_req_o.epc_value = commit_i.pc - 32'd4;
      end else begin
         exc_req_o.epc_value = commit_i.pc;
      end

      exc_req_o.badvaddr_we = retire & exc_hit & (bad_from_pc | bad_from_mem);
      if (bad_from_pc) begin
         exc_req_o.badvaddr = commit_i.pc;
      end else begin
         exc_req_o.badvaddr = commit_i.mem_addr;
      end
   end

   assign flush_o = exc_req_o.take | exc_req_o.eret;

   always_comb begin
      if (exc_req_o.eret) begin
         redirect_pc_o = epc_i;
      end else begin
         redirect_pc_o = `CP0_EXC_VECTOR;
      end
   end

endmodule

/* cp0_pkg.sv */
package cp0_pkg;

   // cp0 register numbers, select 0 only
   typedef enum logic [4:0] {
      BADVADDR = 5'd8,
      COUNT    = 5'd9,
      COMPARE  = 5'd11,
      STATUS   = 5'd12,
      CAUSE    = 5'd13,
      EPC      = 5'd14,
      PRID     = 5'd15,
      CONFIG   = 5'd16
   } cp0_addr_e;

   typedef enum logic [4:0] {
      INT  = 5'd0,
      ADEL = 5'd4,
      ADES = 5'd5,
      SYS  = 5'd8,
      BP   = 5'd9,
      RI   = 5'd10,
      OV   = 5'd12
   } exc_code_e;

   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      logic        in_delay_slot;
      logic        adel_fetch;    // misaligned pc
      logic        ri;
      logic        ov;
      logic        sys;
      logic        bp;
      logic        adel_load;
      logic        ades;
      logic        eret;
      logic [31:0] mem_addr;      // load/store address
   } commit_t;

   typedef struct packed {
      logic        take;
      logic        eret;
      exc_code_e   code;
      logic [31:0] epc_value;     // delay slot already folded in
      logic        bd;
      logic        badvaddr_we;
      logic [31:0] badvaddr;
   } exc_req_t;

   typedef struct packed {
      logic        we;
      cp0_addr_e   addr;
      logic [31:0] data;
   } cp0_wr_t;

endpackage

/* cp0_regs.sv */
`timescale 1ns/1ps

`include "cp0_settings.svh"

module cp0_regs (
   input  logic               clk,
   input  logic               rst,
   input  logic               stall_i,
   input  logic [5:0]         ext_int_i,
   input  cp0_pkg::exc_req_t  exc_req_i,
   input  cp0_pkg::cp0_wr_t   wr_i,
   input  cp0_pkg::cp0_addr_e rd_addr_i,
   output logic [31:0]        rd_data_o,
   output logic [31:0]        status_o,
   output logic [31:0]        cause_o,
   output logic [31:0]        epc_o,
   output logic               timer_int_o
);

   logic [32:0]        count_q;     // lsb is the divide-by-two stage
   logic [31:0]        count;
   logic [31:0]        compare_q;
   logic               timer_q;
   logic [31:0]        status_q;
   logic [31:0]        epc_q;
   logic [31:0]        badvaddr_q;
   logic               cause_bd_q;
   logic [7:0]         cause_ip_q;
   cp0_pkg::exc_code_e cause_exc_q;
   logic               mtc0_en;

   assign count = count_q[32:1];

   // exception or eret in the same cycle drops the write
   assign mtc0_en = wr_i.we & ~stall_i & ~exc_req_i.take & ~exc_req_i.eret;

   // timer keeps running through stalls
   always_ff @(posedge clk) begin
      if (rst) begin
         count_q   <= '0;
         compare_q <= '0;
         timer_q   <= 1'b0;
      end else begin
         count_q <= count_q + 33'd1;
         if (compare_q != 32'd0 && count == compare_q) begin
            timer_q <= 1'b1;  // sticky until compare is written
         end
         if (mtc0_en && wr_i.addr == cp0_pkg::COUNT) begin
            count_q <= {wr_i.data, 1'b0};
         end
         if (mtc0_en && wr_i.addr == cp0_pkg::COMPARE) begin
            compare_q <= wr_i.data;
            timer_q   <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         status_q    <= `CP0_RST_STATUS;
         epc_q       <= '0;
         cause_bd_q  <= 1'b0;
         cause_ip_q  <= '0;
         cause_exc_q <= cp0_pkg::INT;
      end else begin
         // ip7 carries the timer on top of ext line 5
         if (!stall_i) begin
            cause_ip_q[7:2] <= {ext_int_i[5] | timer_q, ext_int_i[4:0]};
         end

         if (exc_req_i.take) begin
            epc_q                     <= exc_req_i.epc_value;
            cause_bd_q                <= exc_req_i.bd;
            cause_exc_q               <= exc_req_i.code;
            status_q[`CP0_STATUS_EXL] <= 1'b1;
         end else if (exc_req_i.eret) begin
            status_q[`CP0_STATUS_EXL] <= 1'b0;
         end else if (mtc0_en) begin
            case (wr_i.addr)
               cp0_pkg::STATUS: begin
                  status_q[`CP0_STATUS_IE]  <= wr_i.data[`CP0_STATUS_IE];
                  status_q[`CP0_STATUS_EXL] <= wr_i.data[`CP0_STATUS_EXL];
                  status_q[`CP0_STATUS_IM_HI:`CP0_STATUS_IM_LO] <=
                     wr_i.data[`CP0_STATUS_IM_HI:`CP0_STATUS_IM_LO];
               end
               cp0_pkg::CAUSE: begin
                  // software interrupt bits only
                  cause_ip_q[1:0] <= wr_i.data[`CP0_CAUSE_IP_LO+1:`CP0_CAUSE_IP_LO];
               end
               cp0_pkg::EPC: begin
                  epc_q <= wr_i.data;
               end
               default: begin
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (exc_req_i.badvaddr_we) begin
         badvaddr_q <= exc_req_i.badvaddr;
      end
   end

   // assemble cause, unused fields read as zero
   always_comb begin
      cause_o = '0;
      cause_o[`CP0_CAUSE_BD] = cause_bd_q;
      cause_o[`CP0_CAUSE_TI] = timer_q;
      cause_o[`CP0_CAUSE_IP_HI:`CP0_CAUSE_IP_LO]   = cause_ip_q;
      cause_o[`CP0_CAUSE_EXC_HI:`CP0_CAUSE_EXC_LO] = cause_exc_q;
   end

   assign status_o    = status_q;
   assign epc_o       = epc_q;
   assign timer_int_o = timer_q;

   // mfc0 port
   always_comb begin
      rd_data_o = '0;
      if (!rst) begin
         case (rd_addr_i)
            cp0_pkg::BADVADDR: rd_data_o = badvaddr_q;
            cp0_pkg::COUNT:    rd_data_o = count;
            cp0_pkg::COMPARE:  rd_data_o = compare_q;
            cp0_pkg::STATUS:   rd_data_o = status_q;
            cp0_pkg::CAUSE:    rd_data_o = cause_o;
            cp0_pkg::EPC:      rd_data_o = epc_q;
            cp0_pkg::PRID:     rd_data_o = `CP0_PRID_VALUE;
            cp0_pkg::CONFIG:   rd_data_o = `CP0_RST_CONFIG;
            default:           rd_data_o = '0;
         endcase
      end
   end

endmodule

/* cp0_settings.svh */
`ifndef CP0_SETTINGS_SVH
`define CP0_SETTINGS_SVH

// status bit positions
`define CP0_STATUS_IE      0
`define CP0_STATUS_EXL     1
`define CP0_STATUS_IM_LO   8
`define CP0_STATUS_IM_HI   15
`define CP0_STATUS_BEV     22

// cause bit positions
`define CP0_CAUSE_EXC_LO   2
`define CP0_CAUSE_EXC_HI   6
`define CP0_CAUSE_IP_LO    8   // ip1..ip0 are software, ip7..ip2 hardware
`define CP0_CAUSE_IP_HI    15
`define CP0_CAUSE_TI       30
`define CP0_CAUSE_BD       31

// reset values
`define CP0_RST_STATUS     (32'h1 << `CP0_STATUS_BEV)
`define CP0_RST_CONFIG     32'h0000_8000
`define CP0_PRID_VALUE     32'h004c_0102

// general exception entry with bev set
`define CP0_EXC_VECTOR     32'hbfc0_0380

`endif

/* cp0_tb.sv */
`timescale 1ns/1ps

`include "cp0_settings.svh"

module cp0_tb;

   localparam logic [31:0] STATUS_WMASK = (32'h1 << `CP0_STATUS_IE)
                                        | (32'h1 << `CP0_STATUS_EXL)
                                        | (32'hff << `CP0_STATUS_IM_LO);
   localparam logic [31:0] EXL_BIT = 32'h1 << `CP0_STATUS_EXL;

   logic               clk = 1'b0;
   logic               rst;
   logic               stall_i;
   cp0_pkg::commit_t   commit_i;
   cp0_pkg::cp0_wr_t   wr_i;
   cp0_pkg::cp0_addr_e rd_addr_i;
   logic [5:0]         ext_int_i;
   logic [31:0]        rd_data_o;
   logic               flush_o;
   logic [31:0]        redirect_pc_o;
   logic               timer_int_o;
   logic [31:0]        seed;
   logic               passed = 1'b0;

   cp0_top dut0 (
      .clk           (clk),
      .rst           (rst),
      .stall_i       (stall_i),
      .commit_i      (commit_i),
      .wr_i          (wr_i),
      .rd_addr_i     (rd_addr_i),
      .ext_int_i     (ext_int_i),
      .rd_data_o     (rd_data_o),
      .flush_o       (flush_o),
      .redirect_pc_o (redirect_pc_o),
      .timer_int_o   (timer_int_o)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   task automatic check_word(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
      assert (got == exp) else begin
         $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("** FAIL **");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic give_up(input string what);
      $display("timed out waiting for %s", what);
      $display("** FAIL **");
      $fatal(1, "timeout");
   endtask

   task automatic write_reg(input cp0_pkg::cp0_addr_e addr, input logic [31:0] data);
      cp0_pkg::cp0_wr_t w;
      w.we   = 1'b1;
      w.addr = addr;
      w.data = data;
      @(posedge clk);
      wr_i <= w;
      @(posedge clk);
      wr_i <= '0;
   endtask

   task automatic read_reg(input cp0_pkg::cp0_addr_e addr, output logic [31:0] data);
      @(posedge clk);
      rd_addr_i <= addr;
      @(negedge clk);  // mfc0 is combinational
      data = rd_data_o;
   endtask

   task automatic expect_reg(input cp0_pkg::cp0_addr_e addr, input logic [31:0] exp,
                             input string what);
      logic [31:0] got;
      read_reg(addr, got);
      check_word(what, got, exp);
   endtask

   // flags[0..6] = adel_fetch, ri, ov, sys, bp, adel_load, ades
   function automatic cp0_pkg::commit_t make_commit(input logic [31:0] pc, input logic ds,
                                                    input logic [6:0] flags,
                                                    input logic eret,
                                                    input logic [31:0] mem);
      cp0_pkg::commit_t c;
      c = '0;
      c.valid         = 1'b1;
      c.pc            = pc;
      c.in_delay_slot = ds;
      c.adel_fetch    = flags[0];
      c.ri            = flags[1];
      c.ov            = flags[2];
      c.sys           = flags[3];
      c.bp            = flags[4];
      c.adel_load     = flags[5];
      c.ades          = flags[6];
      c.eret          = eret;
      c.mem_addr      = mem;
      return c;
   endfunction

   function automatic logic [4:0] flag_code(input int idx);
      case (idx)
         0:       return cp0_pkg::ADEL;
         1:       return cp0_pkg::RI;
         2:       return cp0_pkg::OV;
         3:       return cp0_pkg::SYS;
         4:       return cp0_pkg::BP;
         5:       return cp0_pkg::ADEL;
         default: return cp0_pkg::ADES;
      endcase
   endfunction

   // one commit, flush sampled mid-cycle
   task automatic retire(input cp0_pkg::commit_t c, input logic st, output logic fl,
                         output logic [31:0] target);
      @(posedge clk);
      commit_i <= c;
      stall_i  <= st;
      @(negedge clk);
      fl     = flush_o;
      target = redirect_pc_o;
      @(posedge clk);
      commit_i <= '0;
      stall_i  <= 1'b0;
   endtask

   task automatic wait_cause_bit(input int bit_pos, input string what);
      logic [31:0] c;
      int          n;
      n = 0;
      read_reg(cp0_pkg::CAUSE, c);
      while (!c[bit_pos] && n < 50) begin
         n++;
         read_reg(cp0_pkg::CAUSE, c);
      end
      if (!c[bit_pos]) give_up(what);
   endtask

   task automatic check_exception(input logic [6:0] flags, input logic ds);
      logic [31:0] pc;
      logic [31:0] mem;
      logic [31:0] target;
      logic [31:0] cause_exp;
      logic        fl;
      int          win;
      pc  = lcg_next() & 32'hffff_fffc;
      mem = lcg_next();
      win = 0;
      for (int i = 6; i >= 0; i--) begin
         if (flags[i]) win = i;  // lowest index has the highest priority
      end
      retire(make_commit(pc, ds, flags, 1'b0, mem), 1'b0, fl, target);
      check_word("flush on exception", {31'd0, fl}, 32'd1);
      check_word("exception redirect", target, `CP0_EXC_VECTOR);
      cause_exp = ({31'd0, ds} << `CP0_CAUSE_BD)
                | ({27'd0, flag_code(win)} << `CP0_CAUSE_EXC_LO);
      expect_reg(cp0_pkg::CAUSE, cause_exp, "cause after exception");
      expect_reg(cp0_pkg::EPC, ds ? pc - 32'd4 : pc, "epc after exception");
      if (win == 0) begin
         expect_reg(cp0_pkg::BADVADDR, pc, "badvaddr of fetch error");
      end else if (win >= 5) begin
         expect_reg(cp0_pkg::BADVADDR, mem, "badvaddr of data error");
      end
      expect_reg(cp0_pkg::STATUS, `CP0_RST_STATUS | EXL_BIT, "status after exception");
      write_reg(cp0_pkg::STATUS, 32'd0);
   endtask

   initial begin
      logic [31:0] r;
      logic [31:0] epc_w;
      logic [31:0] target;
      logic [31:0] cause_before;
      logic [31:0] epc_before;
      logic        fl;
      int          line;
      int          n;
      seed      = 32'd89;
      rst       = 1'b1;
      stall_i   = 1'b0;
      commit_i  = '0;
      wr_i      = '0;
      rd_addr_i = cp0_pkg::STATUS;
      ext_int_i = '0;
      @(negedge clk);
      check_word("read during reset", rd_data_o, 32'd0);
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      expect_reg(cp0_pkg::STATUS, `CP0_RST_STATUS, "status reset");
      expect_reg(cp0_pkg::PRID, `CP0_PRID_VALUE, "prid");
      expect_reg(cp0_pkg::CONFIG, `CP0_RST_CONFIG, "config");
      expect_reg(cp0_pkg::CAUSE, 32'd0, "cause reset");
      expect_reg(cp0_pkg::EPC, 32'd0, "epc reset");

      repeat (4) begin
         r = lcg_next();
         write_reg(cp0_pkg::STATUS, r);
         expect_reg(cp0_pkg::STATUS, (`CP0_RST_STATUS & ~STATUS_WMASK) | (r & STATUS_WMASK),
                    "status write");
         r = lcg_next();
         write_reg(cp0_pkg::CAUSE, r);
         expect_reg(cp0_pkg::CAUSE, r & (32'h3 << `CP0_CAUSE_IP_LO), "cause write");
         r = lcg_next();
         write_reg(cp0_pkg::EPC, r);
         expect_reg(cp0_pkg::EPC, r, "epc write");
         r = lcg_next();
         write_reg(cp0_pkg::COMPARE, r);
         expect_reg(cp0_pkg::COMPARE, r, "compare write");
      end
      write_reg(cp0_pkg::CAUSE, 32'd0);
      write_reg(cp0_pkg::STATUS, 32'd0);
      write_reg(cp0_pkg::COMPARE, 32'd0);

      for (int f = 0; f < 7; f++) begin
         check_exception(7'd1 << f, 1'b0);
         check_exception(7'd1 << f, 1'b1);
      end
      repeat (6) begin  // several flags at once
         r = lcg_next();
         if ($countones(r[6:0]) < 2) r[6:0] = r[6:0] | 7'h41;
         check_exception(r[6:0], r[7]);
      end

      epc_w = lcg_next() & 32'hffff_fffc;
      write_reg(cp0_pkg::EPC, epc_w);
      write_reg(cp0_pkg::STATUS, EXL_BIT);
      retire(make_commit(lcg_next(), 1'b0, 7'd0, 1'b1, 32'd0), 1'b0, fl, target);
      check_word("flush on eret", {31'd0, fl}, 32'd1);
      check_word("eret redirect", target, epc_w);
      expect_reg(cp0_pkg::STATUS, `CP0_RST_STATUS, "status after eret");

      // stalled commit is ignored
      read_reg(cp0_pkg::CAUSE, cause_before);
      read_reg(cp0_pkg::EPC, epc_before);
      retire(make_commit(lcg_next(), 1'b1, 7'h08, 1'b0, 32'd0), 1'b1, fl, target);
      check_word("flush while stalled", {31'd0, fl}, 32'd0);
      expect_reg(cp0_pkg::CAUSE, cause_before, "cause after stalled commit");
      expect_reg(cp0_pkg::EPC, epc_before, "epc after stalled commit");
      expect_reg(cp0_pkg::STATUS, `CP0_RST_STATUS, "status after stalled commit");

      line = int'(lcg_next() % 32'd6);
      write_reg(cp0_pkg::STATUS, (32'h1 << `CP0_STATUS_IE)
                               | (32'h1 << (`CP0_STATUS_IM_LO + 2 + line)));
      @(posedge clk);
      ext_int_i <= 6'd1 << line;
      wait_cause_bit(`CP0_CAUSE_IP_LO + 2 + line, "external interrupt in cause");
      r = lcg_next() & 32'hffff_fffc;
      retire(make_commit(r, 1'b0, 7'd0, 1'b0, 32'd0), 1'b0, fl, target);
      check_word("flush on interrupt", {31'd0, fl}, 32'd1);
      check_word("interrupt redirect", target, `CP0_EXC_VECTOR);
      expect_reg(cp0_pkg::CAUSE, (32'h1 << (`CP0_CAUSE_IP_LO + 2 + line))
                               | ({27'd0, cp0_pkg::INT} << `CP0_CAUSE_EXC_LO),
                 "cause after interrupt");
      expect_reg(cp0_pkg::EPC, r, "epc after interrupt");
      retire(make_commit(lcg_next(), 1'b0, 7'd0, 1'b0, 32'd0), 1'b0, fl, target);
      check_word("interrupt with exl set", {31'd0, fl}, 32'd0);
      write_reg(cp0_pkg::STATUS, 32'h1 << (`CP0_STATUS_IM_LO + 2 + line));
      retire(make_commit(lcg_next(), 1'b0, 7'd0, 1'b0, 32'd0), 1'b0, fl, target);
      check_word("interrupt with ie clear", {31'd0, fl}, 32'd0);
      @(posedge clk);
      ext_int_i <= '0;
      write_reg(cp0_pkg::STATUS, 32'd0);

      write_reg(cp0_pkg::COUNT, 32'd0);
      write_reg(cp0_pkg::COMPARE, 32'd4 + (lcg_next() & 32'h7));
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!timer_int_o && n < 200);
      if (!timer_int_o) give_up("timer interrupt");
      wait_cause_bit(`CP0_CAUSE_TI, "timer bit in cause");
      write_reg(cp0_pkg::COMPARE, 32'd0);
      @(negedge clk);
      check_word("timer after compare write", {31'd0, timer_int_o}, 32'd0);
      read_reg(cp0_pkg::CAUSE, r);
      check_word("cause ti after compare write", {31'd0, r[`CP0_CAUSE_TI]}, 32'd0);

      passed = 1'b1;
      $display("** PASS **");
      $finish;
   end

   // run ended without reaching the end of the sequence
   final begin
      if (!passed) $display("** FAIL **");
   end

endmodule

/* cp0_top.sv */
`timescale 1ns/1ps

module cp0_top (
   input  logic               clk,
   input  logic               rst,
   input  logic               stall_i,
   input  cp0_pkg::commit_t   commit_i,
   input  cp0_pkg::cp0_wr_t   wr_i,
   input  cp0_pkg::cp0_addr_e rd_addr_i,
   input  logic [5:0]         ext_int_i,
   output logic [31:0]        rd_data_o,
   output logic               flush_o,
   output logic [31:0]        redirect_pc_o,
   output logic               timer_int_o
);

   cp0_pkg::exc_req_t exc_req;
   logic [31:0]       status;
   logic [31:0]       cause;
   logic [31:0]       epc;

   // commit-stage decision, same cycle
   cp0_exc_resolve resolve0 (
      .commit_i      (commit_i),
      .stall_i       (stall_i),
      .status_i      (status),
      .cause_i       (cause),
      .epc_i         (epc),
      .exc_req_o     (exc_req),
      .flush_o       (flush_o),
      .redirect_pc_o (redirect_pc_o)
   );

   cp0_regs regs0 (
      .clk         (clk),
      .rst         (rst),
      .stall_i     (stall_i),
      .ext_int_i   (ext_int_i),
      .exc_req_i   (exc_req),
      .wr_i        (wr_i),
      .rd_addr_i   (rd_addr_i),
      .rd_data_o   (rd_data_o),
      .status_o    (status),
      .cause_o     (cause),
      .epc_o       (epc),
      .timer_int_o (timer_int_o)
   );

endmodule

/* run_sim.sh */
#!/bin/sh
# build the cp0 testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module cp0_tb \
   -f sources.f \
   -o cp0_sim

status=0
./obj_dir/cp0_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q '\*\* FAIL \*\*' sim.log; then
   echo "simulation failed, see sim.log"
   exit 1
fi

echo "simulation finished cleanly"

/* sources.f */
+incdir+.
cp0_pkg.sv
cp0_exc_resolve.sv
cp0_regs.sv
cp0_top.sv
cp0_asserts.sv
cp0_tb.sv
